// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --timescale 1ns/1ps
TOP = banked_regfile_tb
FLIST = flist.f
OBJ_DIR = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
src/regfile_cfg_pkg.sv
src/regfile_port_pkg.sv
src/regfile_bank.sv
src/read_combiner.sv
src/banked_regfile.sv
testbench/banked_regfile_tb.sv

// ==== src/banked_regfile.sv ====
`timescale 1ns/1ps

module banked_regfile (
	input logic clk,
	input logic reset,

	// Write port 0 reaches bank 0 only and port 1 reaches bank 1 only.
	input regfile_port_pkg::write_port_t write0,
	input regfile_port_pkg::write_port_t write1,

	// Three read ports over all 32 registers.
	input regfile_port_pkg::read_addrs_t read_addrs,
	output regfile_port_pkg::read_data_t read_data
);

	import regfile_cfg_pkg::*;
	import regfile_port_pkg::*;

	bank_read_addrs_t local_addrs; // Shared by both banks.
	logic [num_read_ports-1:0] bank_select;
	read_data_t bank0_data;
	read_data_t bank1_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address split
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Both banks read the local index. The bank bit only steers the result.
	always_comb begin
		local_addrs.a0 = reg_local(read_addrs.a0);
		local_addrs.a1 = reg_local(read_addrs.a1);
		local_addrs.a2 = reg_local(read_addrs.a2);

		bank_select[0] = reg_bank(read_addrs.a0);
		bank_select[1] = reg_bank(read_addrs.a1);
		bank_select[2] = reg_bank(read_addrs.a2);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Banks and combiner
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	regfile_bank bank0 (
		.clk(clk),
		.reset(reset),
		.write(write0),
		.read_addrs(local_addrs),
		.read_data(bank0_data)
	);

	regfile_bank bank1 (
		.clk(clk),
		.reset(reset),
		.write(write1),
		.read_addrs(local_addrs),
		.read_data(bank1_data)
	);

	read_combiner combiner0 (
		.clk(clk),
		.reset(reset),
		.bank_select(bank_select),
		.bank0_data(bank0_data),
		.bank1_data(bank1_data),
		.read_data(read_data)
	);

endmodule

// ==== src/read_combiner.sv ====
`timescale 1ns/1ps

module read_combiner (
	input logic clk,
	input logic reset,

	// Bank bit of each read address. Bit N belongs to port N.
	input logic [regfile_cfg_pkg::num_read_ports-1:0] bank_select,

	// Registered read results of the two banks.
	input regfile_port_pkg::read_data_t bank0_data,
	input regfile_port_pkg::read_data_t bank1_data,

	output regfile_port_pkg::read_data_t read_data
);

	import regfile_cfg_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Select registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic [num_read_ports-1:0] select_q;

	// Sampled on the same edge as the banks sample the local addresses.
	// The choice therefore stays with the data even if the address moves on.
	always_ff @(posedge clk) begin
		if (reset) begin
			select_q <= '0;
		end else begin
			select_q <= bank_select;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output multiplexers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic word_t pick(input logic from_bank1, input word_t word0,
			input word_t word1);
		return from_bank1 ? word1 : word0;
	endfunction

	// Purely combinational, so the port latency stays at one cycle.
	always_comb begin
		read_data.d0 = pick(select_q[0], bank0_data.d0, bank1_data.d0);
		read_data.d1 = pick(select_q[1], bank0_data.d1, bank1_data.d1);
		read_data.d2 = pick(select_q[2], bank0_data.d2, bank1_data.d2);
	end

endmodule

// ==== src/regfile_bank.sv ====
`timescale 1ns/1ps

module regfile_bank (
	input logic clk,
	input logic reset,

	// Write port for this bank.
	input regfile_port_pkg::write_port_t write,

	// Three read ports with bank-local addresses.
	input regfile_port_pkg::bank_read_addrs_t read_addrs,
	output regfile_port_pkg::read_data_t read_data
);

	import regfile_cfg_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	word_t storage [0:bank_depth-1]; // Holds X until first written.

	// A low strobe writes the word at the sampled edge.
	always_ff @(posedge clk) begin
		if (!write.write_n) begin
			storage[write.addr] <= write.data;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Each port registers its word one cycle after the address is seen.
	// The nonblocking write above lands after these reads sample storage,
	// so a read and a write to the same register on one edge give the old word.
	always_ff @(posedge clk) begin
		if (reset) begin
			read_data <= '0;
		end else begin
			read_data.d0 <= storage[read_addrs.a0];
			read_data.d1 <= storage[read_addrs.a1];
			read_data.d2 <= storage[read_addrs.a2];
		end
	end

endmodule

// ==== src/regfile_cfg_pkg.sv ====
package regfile_cfg_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register file geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int word_width = 16; // Width of one register.
	localparam int num_banks = 2;
	localparam int bank_addr_width = 4; // Index of a register inside one bank.
	localparam int bank_depth = 1 << bank_addr_width;

	// The register number is the bank bit on top of the local index.
	localparam int bank_select_width = $clog2(num_banks);
	localparam int reg_addr_width = bank_select_width + bank_addr_width;

	localparam int num_read_ports = 3;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Scalar types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [word_width-1:0] word_t;
	typedef logic [bank_addr_width-1:0] bank_addr_t;
	typedef logic [reg_addr_width-1:0] reg_addr_t; // MSB selects the bank.

	// Bank that holds a given register number.
	function automatic logic reg_bank(input reg_addr_t addr);
		return addr[reg_addr_width-1];
	endfunction

	// Index of a given register number inside its bank.
	function automatic bank_addr_t reg_local(input reg_addr_t addr);
		return addr[bank_addr_width-1:0];
	endfunction

endpackage

// ==== src/regfile_port_pkg.sv ====
package regfile_port_pkg;

	import regfile_cfg_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// One write port drives one bank only, so it carries a local index.
	typedef struct packed {
		logic write_n; // Active low. The strobe is sampled on every rising edge.
		bank_addr_t addr;
		word_t data;
	} write_port_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Full register numbers for the three read ports.
	typedef struct packed {
		reg_addr_t a0;
		reg_addr_t a1;
		reg_addr_t a2;
	} read_addrs_t;

	// The same three addresses with the bank bit stripped off.
	typedef struct packed {
		bank_addr_t a0;
		bank_addr_t a1;
		bank_addr_t a2;
	} bank_read_addrs_t;

	// Read results, one word per port.
	// Field dN always belongs to address aN.
	typedef struct packed {
		word_t d0;
		word_t d1;
		word_t d2;
	} read_data_t;

endpackage

// ==== testbench/banked_regfile_tb.sv ====
`timescale 1ns/1ps

module banked_regfile_tb;

	import regfile_cfg_pkg::*;
	import regfile_port_pkg::*;

	localparam int half_period = 4;
	localparam int reset_cycles = 4;
	localparam int edge_timeout = 20; // Counted in 1 ns polls. This is well over one clock period.
	localparam int fields_per_case = 14;
	localparam int max_cases = 64;
	localparam int random_cycles = 500;
	localparam write_port_t idle_write = '{write_n: 1'b1, addr: 4'h0, data: 16'h0000};

	logic clk;
	logic reset;
	write_port_t write0;
	write_port_t write1;
	read_addrs_t read_addrs;
	read_data_t read_data;

	int edge_count = 0;
	int checks;
	int errors;
	logic [15:0] case_words [0:fields_per_case*max_cases-1];

	// Expected read results for the addresses applied one cycle earlier.
	read_data_t pending_exp;
	logic [num_read_ports-1:0] pending_care;

	logic [15:0] lfsr_state;
	word_t model [0:31];
	logic model_written [0:31];

	banked_regfile dut0 (
		.clk(clk),
		.reset(reset),
		.write0(write0),
		.write1(write1),
		.read_addrs(read_addrs),
		.read_data(read_data)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#half_period;
			clk = ~clk;
			if (clk) begin
				edge_count++;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Timing and checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Returns 1 ns after the next rising edge. Polls sit between clock toggles.
	task automatic next_drive_point();
		int start;
		int polls;
		start = edge_count;
		polls = 0;
		#0.5;
		while (edge_count == start && polls < edge_timeout) begin
			#1;
			polls++;
		end
		if (edge_count == start) begin
			$display("Timeout: the clock showed no rising edge within %0d ns",
				edge_timeout);
			$display("CHECKS FAILED");
			$finish;
		end else begin
			#0.5;
		end
	endtask

	task automatic check(input string name, input word_t actual, input word_t expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error at %0.1f ns: %s is %h, expected %h", $realtime, name, actual,
				expected);
		end
	endtask

	task automatic report_test(input string name, input int checks_before,
			input int errors_before);
		$display("test %s done: %0d checks, %0d errors", name, checks - checks_before,
			errors - errors_before);
	endtask

	// One clock cycle: apply new inputs, then check the reads of the previous cycle.
	task automatic run_cycle(input write_port_t w0, input write_port_t w1,
			input read_addrs_t addrs, input read_data_t exp,
			input logic [num_read_ports-1:0] care);
		next_drive_point();
		write0 = w0;
		write1 = w1;
		read_addrs = addrs;
		#6; // Just before the next rising edge.
		if (pending_care[0]) check("read_data.d0", read_data.d0, pending_exp.d0);
		if (pending_care[1]) check("read_data.d1", read_data.d1, pending_exp.d1);
		if (pending_care[2]) check("read_data.d2", read_data.d2, pending_exp.d2);
		pending_exp = exp;
		pending_care = care;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus sources
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic run_case(input int base);
		write_port_t w0;
		write_port_t w1;
		read_addrs_t addrs;
		read_data_t exp;
		w0.write_n = case_words[base+1][0];
		w0.addr = case_words[base+2][3:0];
		w0.data = case_words[base+3];
		w1.write_n = case_words[base+4][0];
		w1.addr = case_words[base+5][3:0];
		w1.data = case_words[base+6];
		addrs.a0 = case_words[base+7][4:0];
		addrs.a1 = case_words[base+8][4:0];
		addrs.a2 = case_words[base+9][4:0];
		exp.d0 = case_words[base+10];
		exp.d1 = case_words[base+11];
		exp.d2 = case_words[base+12];
		run_cycle(w0, w1, addrs, exp, case_words[base+13][2:0]);
	endtask

	// Taps 16, 14, 13 and 11. One step per bit handed out.
	function automatic logic [15:0] take_bits(input int count);
		logic [15:0] value;
		logic feedback;
		int i;
		value = '0;
		for (i = 0; i < count; i++) begin
			feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], feedback};
			value = {value[14:0], feedback};
		end
		return value;
	endfunction

	task automatic random_cycle();
		write_port_t w0;
		write_port_t w1;
		read_addrs_t addrs;
		read_data_t exp;
		logic [num_read_ports-1:0] care;
		logic [15:0] bits;
		bits = take_bits(1);
		w0.write_n = bits[0];
		bits = take_bits(4);
		w0.addr = bits[3:0];
		w0.data = take_bits(16);
		bits = take_bits(1);
		w1.write_n = bits[0];
		bits = take_bits(4);
		w1.addr = bits[3:0];
		w1.data = take_bits(16);
		bits = take_bits(5);
		addrs.a0 = bits[4:0];
		bits = take_bits(5);
		addrs.a1 = bits[4:0];
		bits = take_bits(5);
		addrs.a2 = bits[4:0];

		// Reads on this edge see the registers before this edge's writes.
		exp.d0 = model[addrs.a0];
		exp.d1 = model[addrs.a1];
		exp.d2 = model[addrs.a2];
		care[0] = model_written[addrs.a0];
		care[1] = model_written[addrs.a1];
		care[2] = model_written[addrs.a2];

		// Port 0 owns registers 0 to 15, port 1 owns 16 to 31.
		if (!w0.write_n) begin
			model[{1'b0, w0.addr}] = w0.data;
			model_written[{1'b0, w0.addr}] = 1'b1;
		end
		if (!w1.write_n) begin
			model[{1'b1, w1.addr}] = w1.data;
			model_written[{1'b1, w1.addr}] = 1'b1;
		end
		run_cycle(w0, w1, addrs, exp, care);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		int i;
		int idx;
		int checks_before;
		int errors_before;
		reset = 1'b1;
		write0 = idle_write;
		write1 = idle_write;
		read_addrs = '0;
		checks = 0;
		errors = 0;
		pending_exp = '0;
		pending_care = '0;
		lfsr_state = 16'd21436;
		for (i = 0; i < 32; i++) begin
			model[i] = '0;
			model_written[i] = 1'b0;
		end
		for (i = 0; i < fields_per_case*max_cases; i++) begin
			case_words[i] = '0;
		end

		repeat (reset_cycles) next_drive_point();
		reset = 1'b0;
		#6;
		check("read_data.d0", read_data.d0, '0); // Nothing has been written yet.
		check("read_data.d1", read_data.d1, '0);
		check("read_data.d2", read_data.d2, '0);
		report_test("reset", 0, 0);

		checks_before = checks;
		errors_before = errors;
		$readmemh("testbench/regfile_cases.txt", case_words);
		idx = 0;
		while (idx < max_cases && case_words[idx*fields_per_case] == 16'h0001) begin
			run_case(idx * fields_per_case);
			idx++;
		end
		run_cycle(idle_write, idle_write, '0, '0, '0);
		if (idx == 0) begin
			errors++;
			$display("No cases could be read from testbench/regfile_cases.txt");
		end
		report_test("directed", checks_before, errors_before);

		checks_before = checks;
		errors_before = errors;
		repeat (random_cycles) random_cycle();
		run_cycle(idle_write, idle_write, '0, '0, '0);
		report_test("random", checks_before, errors_before);

		$display("checks: %0d passed, %0d failed", checks - errors, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== testbench/regfile_cases.txt ====
// valid w0_n w0_addr w0_data w1_n w1_addr w1_data a0 a1 a2 exp_d0 exp_d1 exp_d2 care
// One line per cycle, hex. care bit N checks port N one cycle later.

// Writes on both ports, then reads across both banks.
1 0 0 1111 0 0 2222 00 10 01 0000 0000 0000 0
1 1 0 0000 1 0 0000 00 10 00 1111 2222 1111 7
1 0 5 a5a5 0 a 5a5a 05 1a 00 0000 0000 1111 4
1 1 0 0000 1 0 0000 05 1a 10 a5a5 5a5a 2222 7

// Read in the cycle of a write, then in the cycle after.
1 0 5 0b0b 0 5 1515 05 05 15 a5a5 a5a5 0000 3
1 1 0 0000 1 0 0000 05 15 05 0b0b 1515 0b0b 7
1 1 0 0000 0 a c3c3 1a 1a 1a 5a5a 5a5a 5a5a 7
1 1 0 0000 1 0 0000 1a 1a 1a c3c3 c3c3 c3c3 7

// Three ports spread over both banks while new registers fill.
1 0 3 3003 0 3 3113 00 15 1a 1111 1515 c3c3 7
1 0 7 7007 0 7 7117 03 13 00 3003 3113 1111 7
1 0 c c00c 0 c c11c 07 17 05 7007 7117 0b0b 7

// Each port swaps bank every cycle with the same local index.
1 1 0 0000 1 0 0000 03 17 0c 3003 7117 c00c 7
1 1 0 0000 1 0 0000 13 07 1c 3113 7007 c11c 7
1 1 0 0000 1 0 0000 03 17 0c 3003 7117 c00c 7
1 1 0 0000 1 0 0000 13 07 1c 3113 7007 c11c 7
1 1 0 0000 1 0 0000 03 17 0c 3003 7117 c00c 7

// One register on all three ports.
1 0 f f00f 0 f f11f 00 00 00 1111 1111 1111 7
1 1 0 0000 1 0 0000 0f 1f 0f f00f f11f f00f 7

// Back to back writes of the same registers.
1 0 0 0001 0 0 1001 00 10 00 1111 2222 1111 7
1 0 0 0002 1 0 0000 00 10 10 0001 1001 1001 7
1 1 0 0000 1 0 0000 00 00 00 0002 0002 0002 7
1 1 0 0000 0 a 0a0a 1a 05 1a c3c3 0b0b c3c3 7
1 1 0 0000 1 0 0000 1a 1a 00 0a0a 0a0a 0002 7

// Same local index written in both banks.
1 0 8 8888 0 8 9999 08 18 08 0000 0000 0000 0
1 1 0 0000 1 0 0000 08 18 1f 8888 9999 f11f 7
1 0 8 ffff 0 8 0000 18 08 18 9999 8888 9999 7
1 1 0 0000 1 0 0000 08 18 03 ffff 0000 3003 7
1 1 0 0000 1 0 0000 1f 0f 13 f11f f00f 3113 7
